// File: Bender.yml
package:
  name: wr_master

sources:
  - include_dirs:
      - common
    files:
      - common/wm_axi_pkg.sv
      - common/wm_xfer_pkg.sv
      - hdl/wm_beat_counter.sv
      - hdl/wm_sequencer.sv
      - write_channel/wm_data_channel.sv
      - write_channel/wm_addr_channel.sv
      - hdl/wm_write_master.sv
  - target: test
    include_dirs:
      - common
    files:
      - tests/tb_wm_write_master.sv

// File: common/wm_axi_pkg.sv
// AXI bus side types
`default_nettype none

`include "wr_master_consts.svh"

package wm_axi_pkg;

  ////////////////////////////////////////////////////////////
  // Write address channel
  ////////////////////////////////////////////////////////////

  // Byte address on the memory side
  typedef logic [`WM_ADDR_WIDTH-1:0] addr_t;

  // Burst length in AXI form, beats minus one
  typedef logic [7:0] awlen_t;

  ////////////////////////////////////////////////////////////
  // Write data channel
  ////////////////////////////////////////////////////////////

  // One data word, same width on stream and memory side
  typedef logic [`WM_DATA_WIDTH-1:0] data_t;

  // Byte enables of one word
  typedef logic [`WM_STRB_WIDTH-1:0] strb_t;

endpackage : wm_axi_pkg

`default_nettype wire

// File: common/wm_xfer_pkg.sv
// Transfer bookkeeping types
`default_nettype none

`include "wr_master_consts.svh"

package wm_xfer_pkg;

  ////////////////////////////////////////////////////////////
  // Request size
  ////////////////////////////////////////////////////////////

  // Byte count as requested, or split into words and leftover bytes
  typedef union packed {
    logic [`WM_SIZE_WIDTH-1:0] byte_count;
    struct packed {
      // Whole data words
      logic [`WM_WORDS_WIDTH-1:0]    words;
      // Bytes used in a trailing partial word, zero when none
      logic [`WM_BYTE_SEL_WIDTH-1:0] rem_bytes;
    } split;
  } xfer_size_u;

  ////////////////////////////////////////////////////////////
  // Counters
  ////////////////////////////////////////////////////////////

  // Beats left in one burst
  typedef logic [`WM_BEAT_CNT_WIDTH-1:0] beat_cnt_t;

  // Bursts left in a transfer
  typedef logic [`WM_TXN_CNT_WIDTH-1:0] txn_cnt_t;

  // Free response slots
  typedef logic [`WM_OUTSTANDING_WIDTH-1:0] outstanding_t;

  ////////////////////////////////////////////////////////////
  // Sequencer FSM
  ////////////////////////////////////////////////////////////

  // Wait, register request, derive counts, run to final response
  typedef enum logic [1:0] {
    IDLE,
    CAPTURE,
    ARM,
    RUN
  } seq_state_e;

endpackage : wm_xfer_pkg

`default_nettype wire

// File: common/wr_master_consts.svh
// Write master constants
`ifndef WR_MASTER_CONSTS_SVH
`define WR_MASTER_CONSTS_SVH

// Bus widths
`define WM_ADDR_WIDTH 32
`define WM_DATA_WIDTH 32
`define WM_SIZE_WIDTH 20

// Protocol burst ceilings
`define WM_MAX_BURST_LEN 256
`define WM_MAX_BURST_BYTES 4096

// Bursts allowed to wait for a write response
`define WM_MAX_OUTSTANDING 8

// Derived widths and working burst size
`define WM_STRB_WIDTH (`WM_DATA_WIDTH/8)
`define WM_BYTE_SEL_WIDTH $clog2(`WM_STRB_WIDTH)
`define WM_BURST_LEN ((`WM_MAX_BURST_BYTES/`WM_STRB_WIDTH) < `WM_MAX_BURST_LEN ? \
  (`WM_MAX_BURST_BYTES/`WM_STRB_WIDTH) : `WM_MAX_BURST_LEN)
`define WM_BURST_BYTES (`WM_BURST_LEN*`WM_STRB_WIDTH)
`define WM_BEAT_CNT_WIDTH $clog2(`WM_BURST_LEN)
`define WM_WORDS_WIDTH (`WM_SIZE_WIDTH-`WM_BYTE_SEL_WIDTH)
`define WM_TXN_CNT_WIDTH (`WM_WORDS_WIDTH-`WM_BEAT_CNT_WIDTH)
`define WM_OUTSTANDING_WIDTH $clog2(`WM_MAX_OUTSTANDING+1)

`endif

// File: hdl/wm_beat_counter.sv
// Loadable up/down counter
`timescale 1ns/100ps
`default_nettype none

module wm_beat_counter #(
  parameter int               width = 8,
  parameter logic [width-1:0] init  = '0
) (
  input  wire               aclk,
  input  wire               areset,
  input  wire               load,
  input  wire               incr,
  input  wire               decr,
  input  wire [width-1:0]   load_value,
  output logic [width-1:0]  count,
  output logic              is_zero
);

  // Zero flag tracks the next count value so both change on the same edge
  always_ff @(posedge aclk) begin
    if (areset) begin
      count   <= init;
      is_zero <= (init == '0);
    end else if (load) begin
      // Load wins over any count request
      count   <= load_value;
      is_zero <= (load_value == '0);
    end else if (incr && !decr) begin
      // All ones wraps round to zero
      count   <= count + 1'b1;
      is_zero <= (count == '1);
    end else if (decr && !incr) begin
      // Zero wraps to all ones, so the flag drops
      count   <= count - 1'b1;
      is_zero <= (count == width'(1));
    end
    // Both or neither requested, hold
  end

endmodule : wm_beat_counter

`default_nettype wire

// File: hdl/wm_sequencer.sv
// Transfer sequencer
`timescale 1ns/100ps
`default_nettype none

`include "wr_master_consts.svh"

module wm_sequencer (
  input  wire                          aclk,
  input  wire                          areset,
  input  wire                          ctrl_start,
  input  wire wm_axi_pkg::addr_t       ctrl_addr_offset,
  input  wire wm_xfer_pkg::xfer_size_u ctrl_xfer_size,
  input  wire                          bvalid,
  input  wire                          w_done,
  output logic                         start,
  output wm_axi_pkg::addr_t            base_addr,
  output wm_xfer_pkg::txn_cnt_t        num_txns,
  output wm_xfer_pkg::beat_cnt_t       final_len,
  output wm_axi_pkg::strb_t            final_strb,
  output logic                         ctrl_done
);
  import wm_axi_pkg::*;
  import wm_xfer_pkg::*;

  // Low address bits inside one burst
  localparam addr_t addr_mask = addr_t'(`WM_BURST_BYTES - 1);

  seq_state_e                    state;
  xfer_size_u                    size_r;
  // Total words minus one
  logic [`WM_WORDS_WIDTH-1:0]    total_len_r;
  // Index of the highest valid byte in the final word
  logic [`WM_BYTE_SEL_WIDTH-1:0] last_byte_r;
  logic                          resp_final;

  ////////////////////////////////////////////////////////////
  // FSM
  ////////////////////////////////////////////////////////////

  always_ff @(posedge aclk) begin
    if (areset) begin
      state     <= IDLE;
      start     <= 1'b0;
      ctrl_done <= 1'b0;
    end else begin
      start     <= 1'b0;
      ctrl_done <= 1'b0;
      case (state)
        IDLE: begin
          // New requests only from here
          if (ctrl_start) begin
            state <= CAPTURE;
          end
        end
        CAPTURE: begin
          state <= ARM;
        end
        ARM: begin
          state <= RUN;
          start <= 1'b1;
        end
        RUN: begin
          // Final response, and all write data already gone
          if (bvalid && resp_final && w_done) begin
            ctrl_done <= 1'b1;
            state     <= IDLE;
          end
        end
        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // Request decode
  ////////////////////////////////////////////////////////////

  always_ff @(posedge aclk) begin
    if (state == IDLE && ctrl_start) begin
      size_r.byte_count <= ctrl_xfer_size.byte_count;
      // Start on a burst boundary
      base_addr         <= ctrl_addr_offset & ~addr_mask;
    end
    if (state == CAPTURE) begin
      // Round up to whole words, then minus one
      total_len_r <= (size_r.split.rem_bytes != '0) ? size_r.split.words
                                                    : size_r.split.words - 1'b1;
      // No leftover bytes wraps to the top byte, so a full word
      last_byte_r <= size_r.split.rem_bytes - 1'b1;
    end
    if (state == ARM) begin
      num_txns  <= total_len_r[`WM_BEAT_CNT_WIDTH +: `WM_TXN_CNT_WIDTH];
      final_len <= total_len_r[`WM_BEAT_CNT_WIDTH-1:0];
      for (int i = 0; i < `WM_STRB_WIDTH; i++) begin
        final_strb[i] <= (i <= last_byte_r);
      end
    end
  end

  // Responses left; zero flag marks the last one expected
  wm_beat_counter #(
    .width ($bits(txn_cnt_t)),
    .init  ('0)
  ) resp_cnt_inst (
    .aclk       (aclk),
    .areset     (areset),
    .load       (start),
    .incr       (1'b0),
    .decr       (bvalid),
    .load_value (num_txns),
    .count      (),
    .is_zero    (resp_final)
  );

endmodule : wm_sequencer

`default_nettype wire

// File: hdl/wm_write_master.sv
// Stream to AXI4 write master
`timescale 1ns/100ps
`default_nettype none

module wm_write_master (
  input  wire                          aclk,
  input  wire                          areset,
  // Request
  input  wire                          ctrl_start,
  input  wire wm_axi_pkg::addr_t       ctrl_addr_offset,
  input  wire wm_xfer_pkg::xfer_size_u ctrl_xfer_size,
  output wire                          ctrl_done,
  // AXI4 write address
  output wire                          m_axi_awvalid,
  input  wire                          m_axi_awready,
  output wm_axi_pkg::addr_t            m_axi_awaddr,
  output wm_axi_pkg::awlen_t           m_axi_awlen,
  // AXI4 write data
  output wire                          m_axi_wvalid,
  input  wire                          m_axi_wready,
  output wm_axi_pkg::data_t            m_axi_wdata,
  output wm_axi_pkg::strb_t            m_axi_wstrb,
  output wire                          m_axi_wlast,
  // AXI4 write response
  input  wire                          m_axi_bvalid,
  output wire                          m_axi_bready,
  // AXI4-Stream input
  input  wire                          s_axis_tvalid,
  output wire                          s_axis_tready,
  input  wire wm_axi_pkg::data_t       s_axis_tdata
);
  import wm_axi_pkg::*;
  import wm_xfer_pkg::*;

  // Transfer setup, held from one start to the next
  logic      start;
  addr_t     base_addr;
  txn_cnt_t  num_txns;
  beat_cnt_t final_len;
  strb_t     final_strb;
  // Data to address side handoff
  logic      burst_first;
  logic      w_done;

  // Responses are always taken
  assign m_axi_bready = 1'b1;

  wm_sequencer wm_sequencer_inst (
    .aclk             (aclk),
    .areset           (areset),
    .ctrl_start       (ctrl_start),
    .ctrl_addr_offset (ctrl_addr_offset),
    .ctrl_xfer_size   (ctrl_xfer_size),
    .bvalid           (m_axi_bvalid),
    .w_done           (w_done),
    .start            (start),
    .base_addr        (base_addr),
    .num_txns         (num_txns),
    .final_len        (final_len),
    .final_strb       (final_strb),
    .ctrl_done        (ctrl_done)
  );

  wm_data_channel wm_data_channel_inst (
    .aclk        (aclk),
    .areset      (areset),
    .start       (start),
    .num_txns    (num_txns),
    .final_len   (final_len),
    .final_strb  (final_strb),
    .tvalid      (s_axis_tvalid),
    .tdata       (s_axis_tdata),
    .wready      (m_axi_wready),
    .tready      (s_axis_tready),
    .wvalid      (m_axi_wvalid),
    .wdata       (m_axi_wdata),
    .wstrb       (m_axi_wstrb),
    .wlast       (m_axi_wlast),
    .burst_first (burst_first),
    .w_done      (w_done)
  );

  wm_addr_channel wm_addr_channel_inst (
    .aclk        (aclk),
    .areset      (areset),
    .start       (start),
    .base_addr   (base_addr),
    .num_txns    (num_txns),
    .final_len   (final_len),
    .burst_first (burst_first),
    .awready     (m_axi_awready),
    .bvalid      (m_axi_bvalid),
    .awvalid     (m_axi_awvalid),
    .awaddr      (m_axi_awaddr),
    .awlen       (m_axi_awlen)
  );

endmodule : wm_write_master

`default_nettype wire

// File: tests/tb_wm_write_master.sv
// Write master testbench
`timescale 1ns/100ps
`default_nettype none

`include "wr_master_consts.svh"

module tb_wm_write_master;
  import wm_axi_pkg::*;
  import wm_xfer_pkg::*;

  localparam int max_cycles = 100000;

  logic       aclk;
  logic       areset;
  logic       ctrl_start;
  addr_t      ctrl_addr_offset;
  xfer_size_u ctrl_xfer_size;
  logic       ctrl_done;
  logic       m_axi_awvalid;
  logic       m_axi_awready;
  addr_t      m_axi_awaddr;
  awlen_t     m_axi_awlen;
  logic       m_axi_wvalid;
  logic       m_axi_wready;
  data_t      m_axi_wdata;
  strb_t      m_axi_wstrb;
  logic       m_axi_wlast;
  logic       m_axi_bvalid;
  logic       m_axi_bready;
  logic       s_axis_tvalid;
  logic       s_axis_tready;
  data_t      s_axis_tdata;

  // Stimulus table and LFSR state
  logic [31:0] test_words [0:63];
  logic [31:0] lfsr;

  wm_write_master wm_write_master_inst (
    .aclk             (aclk),
    .areset           (areset),
    .ctrl_start       (ctrl_start),
    .ctrl_addr_offset (ctrl_addr_offset),
    .ctrl_xfer_size   (ctrl_xfer_size),
    .ctrl_done        (ctrl_done),
    .m_axi_awvalid    (m_axi_awvalid),
    .m_axi_awready    (m_axi_awready),
    .m_axi_awaddr     (m_axi_awaddr),
    .m_axi_awlen      (m_axi_awlen),
    .m_axi_wvalid     (m_axi_wvalid),
    .m_axi_wready     (m_axi_wready),
    .m_axi_wdata      (m_axi_wdata),
    .m_axi_wstrb      (m_axi_wstrb),
    .m_axi_wlast      (m_axi_wlast),
    .m_axi_bvalid     (m_axi_bvalid),
    .m_axi_bready     (m_axi_bready),
    .s_axis_tvalid    (s_axis_tvalid),
    .s_axis_tready    (s_axis_tready),
    .s_axis_tdata     (s_axis_tdata)
  );

  initial begin
    aclk = 1'b0;
    forever begin
      #20 aclk = ~aclk;
    end
  end

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////

  task automatic stop_on_error(input string line);
    $display("%s", line);
    $display("** FAIL **");
    $fatal(1);
  endtask

  // Fibonacci LFSR, taps 32 22 2 1, one step per bit
  task automatic take_bits(input int n, output logic [31:0] v);
    logic fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      v    = {v[30:0], fb};
    end
  endtask

  task automatic check_addr(input addr_t got, input addr_t exp, input string what);
    if (got !== exp) begin
      stop_on_error($sformatf("FAIL t=%0t %s got %h expected %h", $time, what, got, exp));
    end
  endtask

  task automatic check_len(input awlen_t got, input awlen_t exp, input string what);
    if (got !== exp) begin
      stop_on_error($sformatf("FAIL t=%0t %s got %h expected %h", $time, what, got, exp));
    end
  endtask

  task automatic check_data(input data_t got, input data_t exp, input string what);
    if (got !== exp) begin
      stop_on_error($sformatf("FAIL t=%0t %s got %h expected %h", $time, what, got, exp));
    end
  endtask

  task automatic check_strb(input strb_t got, input strb_t exp, input string what);
    if (got !== exp) begin
      stop_on_error($sformatf("FAIL t=%0t %s got %h expected %h", $time, what, got, exp));
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      stop_on_error($sformatf("FAIL t=%0t %s got %b expected %b", $time, what, got, exp));
    end
  endtask

  ////////////////////////////////////////////////////////////
  // One transfer with random stream, memory and response timing
  ////////////////////////////////////////////////////////////

  task automatic run_transfer(input addr_t addr, input logic [19:0] size, input int bursts,
                              input awlen_t flen, input strb_t fstrb);
    int          total_words;
    int          cycles;
    int          w_idx;
    int          aw_cnt;
    int          last_cnt;
    int          b_cnt;
    int          first_cnt;
    int          bdelay;
    logic        accepted;
    logic        need_word;
    logic        resent;
    logic        b_prev_final;
    logic        finished;
    logic        last_exp;
    logic        resp_due;
    addr_t       base;
    data_t       cur_word;
    logic [31:0] r;
    total_words  = (int'(size) + 3) / 4;
    base         = addr & ~addr_t'(`WM_BURST_BYTES - 1);
    cycles       = 0;
    w_idx        = 0;
    aw_cnt       = 0;
    last_cnt     = 0;
    b_cnt        = 0;
    first_cnt    = 0;
    bdelay       = 0;
    accepted     = 1'b0;
    need_word    = 1'b1;
    resent       = 1'b0;
    b_prev_final = 1'b0;
    finished     = 1'b0;
    cur_word     = '0;
    while (!finished) begin
      @(negedge aclk);
      // Request, plus a second pulse that the running FSM must ignore
      ctrl_start = 1'b0;
      if (cycles == 0) begin
        ctrl_start                = 1'b1;
        ctrl_addr_offset          = addr;
        ctrl_xfer_size.byte_count = size;
      end else if (w_idx >= 1 && !resent) begin
        ctrl_start                = 1'b1;
        ctrl_addr_offset          = ~addr;
        ctrl_xfer_size.byte_count = 20'h00040;
        resent                    = 1'b1;
      end
      // Stream source keeps a word valid until it is taken
      if (need_word) begin
        take_bits(32, r);
        cur_word  = r;
        need_word = 1'b0;
      end
      if (!s_axis_tvalid || accepted) begin
        take_bits(2, r);
        s_axis_tvalid = (w_idx < total_words) && (r[1:0] != 2'b00);
      end
      s_axis_tdata = cur_word;
      take_bits(2, r);
      m_axi_wready = (r[1:0] != 2'b00);
      take_bits(1, r);
      m_axi_awready = r[0];
      // Responder answers a burst once its address and last word are in
      // Long transfers get no response until the stream ends, so every slot fills up
      resp_due = (b_cnt < aw_cnt) && (b_cnt < last_cnt) &&
                 (bursts <= `WM_MAX_OUTSTANDING || w_idx == total_words);
      if (resp_due && bdelay == 0) begin
        m_axi_bvalid = 1'b1;
        take_bits(6, r);
        bdelay = int'(r[5:0]);
      end else begin
        m_axi_bvalid = 1'b0;
        if (resp_due) begin
          bdelay--;
        end
      end
      #10;
      // Outputs settled; handshakes below take place on the next rising edge
      if (m_axi_awvalid && aw_cnt >= first_cnt) begin
        stop_on_error("Address was issued before the first word of its burst was valid");
      end
      if (m_axi_wvalid && (w_idx % `WM_BURST_LEN) == 0 &&
          first_cnt == w_idx / `WM_BURST_LEN) begin
        first_cnt++;
      end
      check_flag(m_axi_bready, 1'b1, "bready");
      check_flag(m_axi_wvalid && m_axi_wready, s_axis_tvalid && s_axis_tready,
                 "stream and write handshakes");
      if (m_axi_bvalid) begin
        b_cnt++;
      end
      if (m_axi_awvalid && m_axi_awready) begin
        if (aw_cnt >= bursts) begin
          stop_on_error("More addresses were issued than the transfer has bursts");
        end
        check_addr(m_axi_awaddr, base + addr_t'(aw_cnt * `WM_BURST_BYTES), "awaddr");
        check_len(m_axi_awlen, (aw_cnt == bursts - 1) ? flen : awlen_t'(8'hff), "awlen");
        aw_cnt++;
        if (aw_cnt - b_cnt > `WM_MAX_OUTSTANDING) begin
          stop_on_error("Too many bursts are waiting for a write response");
        end
      end
      accepted = m_axi_wvalid && m_axi_wready;
      if (accepted) begin
        if (w_idx >= total_words) begin
          stop_on_error("More words were written than the transfer holds");
        end
        last_exp = ((w_idx % `WM_BURST_LEN) == `WM_BURST_LEN - 1) ||
                   (w_idx == total_words - 1);
        check_data(m_axi_wdata, cur_word, "wdata");
        check_strb(m_axi_wstrb, (w_idx == total_words - 1) ? fstrb : strb_t'('1), "wstrb");
        check_flag(m_axi_wlast, last_exp, "wlast");
        if (m_axi_wlast) begin
          last_cnt++;
        end
        w_idx++;
        need_word = 1'b1;
      end
      // Done exactly one cycle after the final response
      check_flag(ctrl_done, b_prev_final, "ctrl_done");
      finished     = ctrl_done;
      b_prev_final = m_axi_bvalid && (b_cnt == bursts);
      cycles++;
      if (cycles > max_cycles) begin
        stop_on_error("Timed out waiting for ctrl_done");
      end
    end
    if (aw_cnt != bursts || b_cnt != bursts || w_idx != total_words) begin
      stop_on_error("Transfer ended with a wrong number of addresses, responses or words");
    end
    // Idle with every input willing; nothing may move and done stays low
    for (int i = 0; i < 12; i++) begin
      @(negedge aclk);
      ctrl_start    = 1'b0;
      s_axis_tvalid = 1'b1;
      m_axi_wready  = 1'b1;
      m_axi_awready = 1'b1;
      m_axi_bvalid  = 1'b0;
      #10;
      check_flag(m_axi_awvalid, 1'b0, "awvalid after done");
      check_flag(m_axi_wvalid, 1'b0, "wvalid after done");
      check_flag(ctrl_done, 1'b0, "ctrl_done repeated");
    end
    s_axis_tvalid = 1'b0;
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////

  initial begin
    int num_tests;
    lfsr                      = 32'hc4d4_2ac7;
    areset                    = 1'b1;
    ctrl_start                = 1'b0;
    ctrl_addr_offset          = '0;
    ctrl_xfer_size.byte_count = '0;
    m_axi_awready             = 1'b0;
    m_axi_wready              = 1'b0;
    m_axi_bvalid              = 1'b0;
    s_axis_tvalid             = 1'b0;
    s_axis_tdata              = '0;
    for (int i = 0; i < 64; i++) begin
      test_words[i] = 'x;
    end
    $readmemh("tests/wm_write_tests.txt", test_words);
    if ($isunknown(test_words[0]) || test_words[0] == 0 || test_words[0] > 12) begin
      stop_on_error("Could not read a valid transfer count from the test file");
    end
    num_tests = int'(test_words[0]);

    repeat (16) @(posedge aclk);
    @(negedge aclk);
    areset = 1'b0;
    #10;
    check_flag(m_axi_awvalid, 1'b0, "awvalid after reset");
    check_flag(m_axi_wvalid, 1'b0, "wvalid after reset");
    check_flag(s_axis_tready, 1'b0, "tready after reset");
    check_flag(ctrl_done, 1'b0, "ctrl_done after reset");

    for (int t = 0; t < num_tests; t++) begin
      run_transfer(test_words[1 + 5 * t], test_words[2 + 5 * t][19:0],
                   int'(test_words[3 + 5 * t]), awlen_t'(test_words[4 + 5 * t]),
                   strb_t'(test_words[5 + 5 * t]));
    end

    $display("** PASS **");
    $finish;
  end

endmodule : tb_wm_write_master

`default_nettype wire

// File: tests/wm_write_tests.txt
// All values hex. First entry is the number of transfers, then one line each
// address  size_bytes  bursts  final_awlen  final_wstrb
7
00001234 00010 1 03 f
20000002 00007 1 01 7
00000ffc 00001 1 00 1
40000400 00400 1 ff f
100007f0 00a02 3 80 3
80000000 02c00 b ff f
00123abc 00005 1 01 1

// File: wr_master.f
+incdir+common
common/wm_axi_pkg.sv
common/wm_xfer_pkg.sv
hdl/wm_beat_counter.sv
hdl/wm_sequencer.sv
write_channel/wm_data_channel.sv
write_channel/wm_addr_channel.sv
hdl/wm_write_master.sv
tests/tb_wm_write_master.sv

// File: write_channel/wm_addr_channel.sv
// Write address channel
`timescale 1ns/100ps
`default_nettype none

`include "wr_master_consts.svh"

module wm_addr_channel (
  input  wire                         aclk,
  input  wire                         areset,
  input  wire                         start,
  input  wire wm_axi_pkg::addr_t      base_addr,
  input  wire wm_xfer_pkg::txn_cnt_t  num_txns,
  input  wire wm_xfer_pkg::beat_cnt_t final_len,
  input  wire                         burst_first,
  input  wire                         awready,
  input  wire                         bvalid,
  output logic                        awvalid,
  output wm_axi_pkg::addr_t           awaddr,
  output wm_axi_pkg::awlen_t          awlen
);
  import wm_axi_pkg::*;
  import wm_xfer_pkg::*;

  logic awxfer;
  // No burst has data waiting for its address
  logic pending_zero;
  logic final_burst;
  // Every response slot taken
  logic stall;

  assign awxfer = awvalid & awready;

  ////////////////////////////////////////////////////////////
  // Address issue
  ////////////////////////////////////////////////////////////

  // Raise only behind data and with a free slot; hold until accepted
  always_ff @(posedge aclk) begin
    if (areset) begin
      awvalid <= 1'b0;
    end else if (!awvalid && !pending_zero && !stall) begin
      awvalid <= 1'b1;
    end else if (awready) begin
      awvalid <= 1'b0;
    end
  end

  // One burst worth of bytes per accepted address
  always_ff @(posedge aclk) begin
    if (start) begin
      awaddr <= base_addr;
    end else if (awxfer) begin
      awaddr <= awaddr + addr_t'(`WM_BURST_BYTES);
    end
  end

  assign awlen = final_burst ? awlen_t'(final_len) : awlen_t'(`WM_BURST_LEN - 1);

  ////////////////////////////////////////////////////////////
  // Tallies
  ////////////////////////////////////////////////////////////

  // Bursts whose first word is seen but address not yet sent
  wm_beat_counter #(
    .width ($bits(txn_cnt_t)),
    .init  ('0)
  ) pending_cnt_inst (
    .aclk       (aclk),
    .areset     (areset),
    .load       (1'b0),
    .incr       (burst_first),
    .decr       (awxfer),
    .load_value ('0),
    .count      (),
    .is_zero    (pending_zero)
  );

  // Addresses still to issue in this transfer
  wm_beat_counter #(
    .width ($bits(txn_cnt_t)),
    .init  ('0)
  ) burst_cnt_inst (
    .aclk       (aclk),
    .areset     (areset),
    .load       (start),
    .incr       (1'b0),
    .decr       (awxfer),
    .load_value (num_txns),
    .count      (),
    .is_zero    (final_burst)
  );

  // Free response slots, taken by an address and returned by a response
  wm_beat_counter #(
    .width ($bits(outstanding_t)),
    .init  (outstanding_t'(`WM_MAX_OUTSTANDING))
  ) vacancy_cnt_inst (
    .aclk       (aclk),
    .areset     (areset),
    .load       (1'b0),
    .incr       (bvalid),
    .decr       (awxfer),
    .load_value ('0),
    .count      (),
    .is_zero    (stall)
  );

endmodule : wm_addr_channel

`default_nettype wire

// File: write_channel/wm_data_channel.sv
// Write data channel
`timescale 1ns/100ps
`default_nettype none

`include "wr_master_consts.svh"

module wm_data_channel (
  input  wire                         aclk,
  input  wire                         areset,
  input  wire                         start,
  input  wire wm_xfer_pkg::txn_cnt_t  num_txns,
  input  wire wm_xfer_pkg::beat_cnt_t final_len,
  input  wire wm_axi_pkg::strb_t      final_strb,
  input  wire                         tvalid,
  input  wire wm_axi_pkg::data_t      tdata,
  input  wire                         wready,
  output logic                        tready,
  output logic                        wvalid,
  output wm_axi_pkg::data_t           wdata,
  output wm_axi_pkg::strb_t           wstrb,
  output logic                        wlast,
  output logic                        burst_first,
  output logic                        w_done
);
  import wm_xfer_pkg::*;

  logic      running;
  logic      wxfer;
  logic      final_txn;
  logic      single_txn;
  logic      almost_final_txn;
  logic      final_xfer;
  logic      beat_load;
  beat_cnt_t beat_load_value;
  txn_cnt_t  bursts_left;
  // Next word opens a burst
  logic      wfirst;
  // First word of this burst already reported
  logic      first_seen;

  ////////////////////////////////////////////////////////////
  // Stream pass-through
  ////////////////////////////////////////////////////////////

  // Nothing moves until the sequencer has armed the counters
  assign wvalid = tvalid & running;
  assign tready = wready & running;
  assign wdata  = tdata;
  assign wxfer  = wvalid & wready;

  assign final_xfer = wxfer & wlast & final_txn;

  // Partial mask only on the closing word of the transfer
  assign wstrb = (wlast && final_txn) ? final_strb : '1;

  always_ff @(posedge aclk) begin
    if (areset) begin
      running <= 1'b0;
      w_done  <= 1'b0;
    end else begin
      if (start) begin
        running <= 1'b1;
        w_done  <= 1'b0;
      end else if (final_xfer) begin
        running <= 1'b0;
        w_done  <= 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Beat and burst tallies
  ////////////////////////////////////////////////////////////

  assign single_txn       = (num_txns == '0);
  assign almost_final_txn = (bursts_left == txn_cnt_t'(1));

  // Short burst comes last; a full burst needs no reload since zero wraps
  assign beat_load       = start | (wxfer & wlast & almost_final_txn);
  assign beat_load_value = (start && !single_txn) ? beat_cnt_t'(`WM_BURST_LEN - 1)
                                                  : final_len;

  wm_beat_counter #(
    .width ($bits(beat_cnt_t)),
    .init  (beat_cnt_t'(`WM_BURST_LEN - 1))
  ) beat_cnt_inst (
    .aclk       (aclk),
    .areset     (areset),
    .load       (beat_load),
    .incr       (1'b0),
    .decr       (wxfer),
    .load_value (beat_load_value),
    .count      (),
    .is_zero    (wlast)
  );

  wm_beat_counter #(
    .width ($bits(txn_cnt_t)),
    .init  ('0)
  ) burst_cnt_inst (
    .aclk       (aclk),
    .areset     (areset),
    .load       (start),
    .incr       (1'b0),
    .decr       (wxfer & wlast),
    .load_value (num_txns),
    .count      (bursts_left),
    .is_zero    (final_txn)
  );

  ////////////////////////////////////////////////////////////
  // First-beat pulse for the address side
  ////////////////////////////////////////////////////////////

  always_ff @(posedge aclk) begin
    if (areset) begin
      wfirst      <= 1'b1;
      first_seen  <= 1'b0;
      burst_first <= 1'b0;
    end else begin
      if (wxfer) begin
        wfirst <= wlast;
      end
      // Cleared by any transfer, so a one-beat burst still gets its pulse
      if (wxfer) begin
        first_seen <= 1'b0;
      end else if (wvalid && wfirst) begin
        first_seen <= 1'b1;
      end
      burst_first <= wvalid & wfirst & ~first_seen;
    end
  end

endmodule : wm_data_channel

`default_nettype wire
